/* Bender.yml */
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - hazard_if.sv
  - pipe_reg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - hazard_unit.sv
  - mem_wb_stage.sv
  - mips_core.sv
  - target: test
    files:
      - tb_mips_core.sv

/* compile.f */
mips_pkg.sv
hazard_if.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
hazard_unit.sv
mem_wb_stage.sv
mips_core.sv
tb_mips_core.sv

/* decode_stage.sv */
/*
 * Decode stage
 * Instruction decoder, register file with writeback bypass
 * and immediate sign extension
 */
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  fd_t         fd,
	hazard_if.dec       hz,
	input  logic        wb_regwrite,
	input  logic [4:0]  wb_reg,
	input  logic [31:0] wb_result,
	output de_t         de
);

	logic [31:0] regs [1:31];
	logic [5:0]  opcode, funct;
	logic [4:0]  rs, rt, rd;
	ctrl_t       ctrl;
	logic [31:0] rd1, rd2;

	assign opcode = fd.instr[31:26];
	assign funct  = fd.instr[5:0];
	assign rs     = fd.instr[25:21];
	assign rt     = fd.instr[20:16];
	assign rd     = fd.instr[15:11];

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst   = 1'b1;
				case (funct)
					F_ADD: ctrl.alu_op = ALU_ADD;
					F_SUB: ctrl.alu_op = ALU_SUB;
					F_AND: ctrl.alu_op = ALU_AND;
					F_OR:  ctrl.alu_op = ALU_OR;
					F_SLT: ctrl.alu_op = ALU_SLT;
					default: ctrl.regwrite = 1'b0;    // Unsupported funct, nop
				endcase
			end
			OP_ADDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			default: ctrl = '0;
		endcase
	end

	// Register 0 is not stored
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_regwrite && wb_reg != 5'd0) begin
			regs[wb_reg] <= wb_result;
		end
	end

	// A result written back this cycle is seen by the read
	always_comb begin
		if (rs == 5'd0) rd1 = '0;
		else if (wb_regwrite && wb_reg == rs) rd1 = wb_result;
		else rd1 = regs[rs];
		if (rt == 5'd0) rd2 = '0;
		else if (wb_regwrite && wb_reg == rt) rd2 = wb_result;
		else rd2 = regs[rt];
	end

	assign hz.dec_rs = rs;
	assign hz.dec_rt = rt;

	assign de.ctrl    = ctrl;
	assign de.rd1     = rd1;
	assign de.rd2     = rd2;
	assign de.imm     = {{16{fd.instr[15]}}, fd.instr[15:0]};
	assign de.pcplus4 = fd.pcplus4;
	assign de.rs      = rs;
	assign de.rt      = rt;
	assign de.rd      = rd;

endmodule

/* execute_stage.sv */
/*
 * Execute stage
 * Forwarded operand selection, ALU, destination register choice
 * and beq resolution with its target address
 */
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; #(
	parameter int XLEN = 32
) (
	input  de_t             de,
	hazard_if.exec          hz,
	input  logic [XLEN-1:0] mem_alu,
	output em_t             em,
	output logic            branch_taken,
	output logic [XLEN-1:0] branch_target
);

	logic [31:0] src_a, src_b_reg, src_b, alu_y;

	always_comb begin
		case (hz.forward_a)
			FWD_MEM: src_a = mem_alu;
			FWD_WB:  src_a = hz.wb_result;
			default: src_a = de.rd1;
		endcase
		case (hz.forward_b)
			FWD_MEM: src_b_reg = mem_alu;
			FWD_WB:  src_b_reg = hz.wb_result;
			default: src_b_reg = de.rd2;
		endcase
	end

	assign src_b = de.ctrl.alusrc ? de.imm : src_b_reg;

	always_comb begin
		case (de.ctrl.alu_op)
			ALU_SUB: alu_y = src_a - src_b;
			ALU_AND: alu_y = src_a & src_b;
			ALU_OR:  alu_y = src_a | src_b;
			ALU_SLT: alu_y = {31'd0, $signed(src_a) < $signed(src_b)};
			default: alu_y = src_a + src_b;
		endcase
	end

	assign branch_taken  = de.ctrl.branch && (alu_y == 32'd0);
	assign branch_target = de.pcplus4 + {de.imm[29:0], 2'b00};    // Word offset from pc+4

	assign hz.ex_rs       = de.rs;
	assign hz.ex_rt       = de.rt;
	assign hz.ex_memtoreg = de.ctrl.memtoreg;
	assign hz.ex_regwrite = de.ctrl.regwrite;

	assign em.regwrite   = de.ctrl.regwrite;
	assign em.memtoreg   = de.ctrl.memtoreg;
	assign em.memwrite   = de.ctrl.memwrite;
	assign em.alu_out    = alu_y;
	assign em.write_data = src_b_reg;    // Store data after forwarding
	assign em.write_reg  = de.ctrl.regdst ? de.rd : de.rt;

endmodule

/* fetch_stage.sv */
/*
 * Fetch stage
 * Program counter with branch redirect and load-use hold
 */
`timescale 1ns/1ps

module fetch_stage #(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            stall,
	input  logic            branch_taken,
	input  logic [XLEN-1:0] branch_target,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] pcplus4
);

	logic [XLEN-1:0] pc_next;

	assign pcplus4 = pc + XLEN'(4);

	always_comb begin
		if (branch_taken) begin
			pc_next = branch_target;    // Redirect from execute
		end else if (stall) begin
			pc_next = pc;
		end else begin
			pc_next = pcplus4;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

/* hazard_if.sv */
/*
 * Hazard signalling between the pipeline stages and the hazard unit
 */
`timescale 1ns/1ps

interface hazard_if import mips_pkg::*; ();

	logic [4:0]  ex_rs, ex_rt;
	logic        ex_memtoreg, ex_regwrite;
	logic [4:0]  mem_reg;
	logic        mem_regwrite;
	logic [4:0]  wb_reg;
	logic        wb_regwrite;
	logic [31:0] wb_result;
	logic [4:0]  dec_rs, dec_rt;
	fwd_t        forward_a, forward_b;
	logic        stall, flush;

	modport exec (output ex_rs, ex_rt, ex_memtoreg, ex_regwrite,
		input forward_a, forward_b, wb_result);
	modport dec  (output dec_rs, dec_rt);
	modport mem  (output mem_reg, mem_regwrite);
	modport wb   (output wb_reg, wb_regwrite, wb_result);
	modport unit (input ex_rs, ex_rt, ex_memtoreg, ex_regwrite, mem_reg, mem_regwrite,
		wb_reg, wb_regwrite, dec_rs, dec_rt, output forward_a, forward_b, stall, flush);

endinterface

/* hazard_unit.sv */
/*
 * Hazard unit
 * Forwarding selects, load-use stall and taken-branch flush
 */
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
	hazard_if.unit hz,
	input  logic   branch_taken
);

	function automatic fwd_t fwd_sel(
		input logic [4:0] src,
		input logic [4:0] mem_reg,
		input logic       mem_regwrite,
		input logic [4:0] wb_reg,
		input logic       wb_regwrite
	);
		fwd_t sel;
		sel = FWD_REG;
		if (src != 5'd0) begin
			if (mem_regwrite && mem_reg == src) sel = FWD_MEM;    // Youngest result wins
			else if (wb_regwrite && wb_reg == src) sel = FWD_WB;
		end
		return sel;
	endfunction

	assign hz.forward_a = fwd_sel(hz.ex_rs, hz.mem_reg, hz.mem_regwrite,
		hz.wb_reg, hz.wb_regwrite);
	assign hz.forward_b = fwd_sel(hz.ex_rt, hz.mem_reg, hz.mem_regwrite,
		hz.wb_reg, hz.wb_regwrite);

	// Load in execute whose data decode needs next cycle
	assign hz.stall = hz.ex_memtoreg && hz.ex_regwrite
		&& (hz.ex_rt == hz.dec_rs || hz.ex_rt == hz.dec_rt);

	assign hz.flush = branch_taken;

endmodule

/* mem_wb_stage.sv */
/*
 * Memory and writeback stage
 * Drives the data memory port and selects the writeback result
 */
`timescale 1ns/1ps

module mem_wb_stage import mips_pkg::*; (
	input  em_t         em,
	input  mw_t         mw_in,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	input  logic [31:0] dmem_rdata,
	output mw_t         mw,
	hazard_if.mem       hz_mem,
	hazard_if.wb        hz_wb,
	output logic        wb_regwrite,
	output logic [4:0]  wb_reg,
	output logic [31:0] wb_result
);

	assign dmem_addr  = em.alu_out;
	assign dmem_wdata = em.write_data;
	assign dmem_we    = em.memwrite;    // Single-cycle write strobe

	assign mw.regwrite  = em.regwrite;
	assign mw.memtoreg  = em.memtoreg;
	assign mw.read_data = dmem_rdata;
	assign mw.alu_out   = em.alu_out;
	assign mw.write_reg = em.write_reg;

	assign hz_mem.mem_reg      = em.write_reg;
	assign hz_mem.mem_regwrite = em.regwrite;

	assign wb_regwrite = mw_in.regwrite;
	assign wb_reg      = mw_in.write_reg;
	assign wb_result   = mw_in.memtoreg ? mw_in.read_data : mw_in.alu_out;

	assign hz_wb.wb_reg      = wb_reg;
	assign hz_wb.wb_regwrite = wb_regwrite;
	assign hz_wb.wb_result   = wb_result;

endmodule

/* mips_core.sv */
/*
 * Five-stage pipelined MIPS subset core
 * Fetch, decode, execute, memory and writeback joined by stage
 * registers, with forwarding, load-use stall and branch flush
 */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            reset,
	output logic [XLEN-1:0] imem_addr,
	input  logic [31:0]     imem_rdata,
	output logic [31:0]     dmem_addr,
	output logic [31:0]     dmem_wdata,
	output logic            dmem_we,
	input  logic [31:0]     dmem_rdata
);

	hazard_if hz ();

	logic [XLEN-1:0] pcplus4, branch_target;
	logic            branch_taken;
	logic            wb_regwrite;
	logic [4:0]      wb_reg;
	logic [31:0]     wb_result;
	fd_t             fd_d, fd_q;
	de_t             de_d, de_q;
	em_t             em_d, em_q;
	mw_t             mw_d, mw_q;

	fetch_stage #(.XLEN(XLEN)) u_fetch (.clk(clk), .reset(reset), .stall(hz.stall),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.pc(imem_addr), .pcplus4(pcplus4));

	assign fd_d.instr   = imem_rdata;
	assign fd_d.pcplus4 = pcplus4;

	pipe_reg #(.payload_t(fd_t)) u_fd_reg (.clk(clk), .reset(reset),
		.enable(!hz.stall), .clear(hz.flush), .d(fd_d), .q(fd_q));

	decode_stage u_decode (.clk(clk), .reset(reset), .fd(fd_q), .hz(hz.dec),
		.wb_regwrite(wb_regwrite), .wb_reg(wb_reg), .wb_result(wb_result), .de(de_d));

	// A stalled decode moves on as a bubble
	pipe_reg #(.payload_t(de_t)) u_de_reg (.clk(clk), .reset(reset),
		.enable(1'b1), .clear(hz.stall || hz.flush), .d(de_d), .q(de_q));

	execute_stage #(.XLEN(XLEN)) u_execute (.de(de_q), .hz(hz.exec), .mem_alu(em_q.alu_out),
		.em(em_d), .branch_taken(branch_taken), .branch_target(branch_target));

	hazard_unit u_hazard (.hz(hz.unit), .branch_taken(branch_taken));

	pipe_reg #(.payload_t(em_t)) u_em_reg (.clk(clk), .reset(reset),
		.enable(1'b1), .clear(1'b0), .d(em_d), .q(em_q));

	mem_wb_stage u_mem_wb (.em(em_q), .mw_in(mw_q), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .dmem_rdata(dmem_rdata), .mw(mw_d),
		.hz_mem(hz.mem), .hz_wb(hz.wb), .wb_regwrite(wb_regwrite), .wb_reg(wb_reg),
		.wb_result(wb_result));

	pipe_reg #(.payload_t(mw_t)) u_mw_reg (.clk(clk), .reset(reset),
		.enable(1'b1), .clear(1'b0), .d(mw_d), .q(mw_q));

endmodule

/* mips_pkg.sv */
/*
 * MIPS subset shared definitions
 * Opcode and funct codes, ALU operations, forwarding selects,
 * the decoded control bundle and the four pipeline stage payloads
 */
package mips_pkg;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	localparam logic [5:0] F_ADD = 6'h20;
	localparam logic [5:0] F_SUB = 6'h22;
	localparam logic [5:0] F_AND = 6'h24;
	localparam logic [5:0] F_OR  = 6'h25;
	localparam logic [5:0] F_SLT = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_t;

	// Operand source chosen by the hazard unit
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwd_t;

	typedef struct packed {
		logic    regwrite;
		logic    memtoreg;
		logic    memwrite;
		logic    branch;
		logic    alusrc;
		logic    regdst;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pcplus4;
	} fd_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic [31:0] imm;
		logic [31:0] pcplus4;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
	} de_t;

	typedef struct packed {
		logic        regwrite;
		logic        memtoreg;
		logic        memwrite;
		logic [31:0] alu_out;
		logic [31:0] write_data;
		logic [4:0]  write_reg;
	} em_t;

	typedef struct packed {
		logic        regwrite;
		logic        memtoreg;
		logic [31:0] read_data;
		logic [31:0] alu_out;
		logic [4:0]  write_reg;
	} mw_t;

endpackage

/* pipe_reg.sv */
/*
 * Pipeline stage register
 * Holds one stage payload, loads when enabled, and loads a zero
 * bubble on a synchronous clear
 */
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     enable,
	input  logic     clear,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;    // Bubble, all control bits low
		end else if (enable) begin
			q <= d;
		end
	end

endmodule

/* tb_mips_core.sv */
/*
 * Testbench for the pipelined MIPS subset core
 * Models both memories, runs a short program with random operands and
 * checks every data memory store, and its timing, against an in-order model
 */
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

	localparam logic [31:0] HALT = {OP_BEQ, 5'd0, 5'd0, 16'hffff};    // beq r0, r0, -1

	logic        clk, reset, dmem_we, model_done;
	logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] model_mem [64];
	int          store_test [64];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	int          exp_edge_q [$];
	int          exp_test_q [$];
	string       test_name [6];
	int          test_left [6];
	int          test_err [6];
	int          errors, stores_seen, n_exp, n_dyn, edge_cnt;
	integer      seed;

	assign imem_rdata = imem[imem_addr[7:2]];
	assign dmem_rdata = dmem[dmem_addr[7:2]];

	mips_core #(.XLEN(32)) DUT (.clk(clk), .reset(reset), .imem_addr(imem_addr),
		.imem_rdata(imem_rdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .dmem_rdata(dmem_rdata));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
	end

	always @(posedge clk or posedge reset) begin
		if (reset) edge_cnt <= 0;
		else edge_cnt <= edge_cnt + 1;    // Edge 1 loads the first instruction
	end

	function automatic logic [31:0] enc_r(input logic [5:0] funct,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check_value(input int id, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("ERROR %s %s: expected %h actual %h", test_name[id], what, exp, act);
			test_err[id]++;
			errors++;
		end
	endtask

	task automatic report_test(input int id);
		$display("Test %-9s %s, %0d errors", test_name[id],
			(test_err[id] == 0) ? "passed" : "failed", test_err[id]);
	endtask

	task automatic retire_store();
		int id;
		id = exp_test_q.pop_front();
		void'(exp_addr_q.pop_front());
		void'(exp_data_q.pop_front());
		void'(exp_edge_q.pop_front());
		test_left[id]--;
		if (test_left[id] == 0) report_test(id);
	endtask

	task automatic put(input int idx, input logic [31:0] word, input int id);
		imem[idx] = word;
		store_test[idx] = id;
	endtask

	task automatic build_program();
		logic [15:0] imm_a, imm_b, imm_c;
		imm_a = $random(seed);
		imm_b = $random(seed);
		imm_c = $random(seed);
		imm_a[0] = 1'b0;    // r1 and r2 always differ
		imm_b[0] = 1'b1;
		for (int i = 0; i < 64; i++) begin
			put(i, 32'd0, 0);
			dmem[i] = '0;
			model_mem[i] = '0;
		end
		put(0, enc_i(OP_ADDI, 0, 1, imm_a), 0);
		put(1, enc_i(OP_ADDI, 0, 2, imm_b), 0);
		put(2, enc_r(F_ADD, 3, 1, 2), 0);
		put(3, enc_r(F_SUB, 4, 3, 1), 0);
		put(4, enc_r(F_AND, 5, 4, 3), 0);
		put(5, enc_r(F_OR, 6, 5, 2), 0);
		put(6, enc_r(F_SLT, 7, 6, 1), 0);
		put(7, enc_i(OP_ADDI, 7, 8, imm_c), 0);
		put(8, enc_i(OP_SW, 0, 8, 16'd4), 1);
		put(9, enc_i(OP_SW, 0, 5, 16'd8), 1);
		put(10, enc_i(OP_SW, 0, 6, 16'd12), 1);
		put(11, enc_i(OP_SW, 0, 7, 16'd16), 1);
		put(12, enc_i(OP_LW, 0, 9, 16'd4), 0);
		put(13, enc_r(F_ADD, 10, 9, 1), 0);    // Load-use
		put(14, enc_i(OP_SW, 0, 10, 16'd20), 2);
		put(15, enc_i(OP_BEQ, 1, 1, 16'd2), 0);    // Taken and skips 16 and 17
		put(16, enc_i(OP_SW, 0, 1, 16'd24), 3);
		put(17, enc_i(OP_SW, 0, 2, 16'd24), 3);
		put(18, enc_i(OP_SW, 0, 3, 16'd28), 3);
		put(19, enc_i(OP_BEQ, 1, 2, 16'd1), 0);    // Never taken
		put(20, enc_i(OP_SW, 0, 4, 16'd32), 3);
		put(21, enc_i(OP_ADDI, 0, 0, imm_c), 0);
		put(22, enc_r(F_ADD, 0, 1, 2), 0);
		put(23, enc_i(OP_SW, 0, 0, 16'd36), 4);
		put(24, enc_r(F_ADD, 11, 0, 2), 0);
		put(25, enc_i(OP_SW, 0, 11, 16'd40), 4);
		put(26, HALT, 0);
	endtask

	// In-order execution; e is the edge that loads the instruction into execute
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] ins, a, b, imm, res;
		logic [4:0]  prev_rt;
		logic        prev_load, taken;
		int          pc, e;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		pc = 0;
		e = 2;
		prev_load = 1'b0;
		prev_rt = '0;
		while (imem[pc] !== HALT && n_dyn < 60) begin
			ins = imem[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			taken = 1'b0;
			if (prev_load && (prev_rt == ins[25:21] || prev_rt == ins[20:16])) e++;
			case (ins[31:26])
				OP_RTYPE: begin
					case (ins[5:0])
						F_ADD: res = a + b;
						F_SUB: res = a - b;
						F_AND: res = a & b;
						F_OR:  res = a | b;
						F_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: res = '0;
					endcase
					if (ins[15:11] != 5'd0) regs[ins[15:11]] = res;
				end
				OP_ADDI: if (ins[20:16] != 5'd0) regs[ins[20:16]] = a + imm;
				OP_LW: if (ins[20:16] != 5'd0) regs[ins[20:16]] = model_mem[(a + imm) >> 2];
				OP_SW: begin
					model_mem[(a + imm) >> 2] = b;
					exp_addr_q.push_back(a + imm);
					exp_data_q.push_back(b);
					exp_edge_q.push_back(e + 1);    // Strobe after the memory stage loads
					exp_test_q.push_back(store_test[pc]);
					test_left[store_test[pc]]++;
					n_exp++;
				end
				OP_BEQ: taken = (a == b);
				default: ;
			endcase
			prev_load = (ins[31:26] == OP_LW);
			prev_rt = ins[20:16];
			pc = taken ? pc + 1 + int'($signed(imm)) : pc + 1;
			e = e + (taken ? 3 : 1);    // Two flushed slots after a taken beq
			n_dyn++;
		end
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			if (dmem_we && exp_addr_q.size() == 0) begin
				$display("Unexpected store of %h to address %h", dmem_wdata, dmem_addr);
				stores_seen++;
				errors++;
			end else if (dmem_we) begin
				check_value(exp_test_q[0], "store address", exp_addr_q[0], dmem_addr);
				check_value(exp_test_q[0], "store data", exp_data_q[0], dmem_wdata);
				check_value(exp_test_q[0], "store edge", exp_edge_q[0], edge_cnt);
				stores_seen++;
				retire_store();
			end else if (exp_edge_q.size() > 0 && edge_cnt >= exp_edge_q[0]) begin
				$display("Store for test %s did not appear at edge %0d",
					test_name[exp_test_q[0]], exp_edge_q[0]);
				test_err[exp_test_q[0]]++;
				errors++;
				retire_store();
			end
		end
	end

	initial begin
		wait (model_done === 1'b1);
		#((4 * n_dyn + 200) * 8);
		$display("Watchdog expired with %0d stores still pending", exp_addr_q.size());
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		reset = 1'b1;
		model_done = 1'b0;
		seed = 32'h5b0fb92d;
		errors = 0;
		stores_seen = 0;
		n_exp = 0;
		n_dyn = 0;
		test_name[0] = "reset";
		test_name[1] = "forward";
		test_name[2] = "load_use";
		test_name[3] = "branch";
		test_name[4] = "reg_zero";
		test_name[5] = "count";
		for (int i = 0; i < 6; i++) begin
			test_left[i] = 0;
			test_err[i] = 0;
		end
		build_program();
		run_model();
		model_done = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_value(0, "imem_addr in reset", 32'd0, imem_addr);
		check_value(0, "dmem_we in reset", 32'd0, dmem_we);
		@(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		check_value(0, "imem_addr before fetch", 32'd0, imem_addr);
		check_value(0, "dmem_we before fetch", 32'd0, dmem_we);
		@(negedge clk);
		check_value(0, "imem_addr after fetch", 32'd4, imem_addr);
		report_test(0);
		while (exp_addr_q.size() != 0) @(negedge clk);
		repeat (10) @(negedge clk);    // Halt loop must add no strobes
		check_value(5, "strobe count", n_exp, stores_seen);
		report_test(5);
		$display("Tests: 6, stores checked: %0d of %0d, errors: %0d",
			stores_seen, n_exp, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
